/* hdl/dma_config.svh */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// external (DDR side) byte address and beat width
`define AXI_AWIDTH 32
`define AXI_DWIDTH 32
`define AXI_STRB_W (`AXI_DWIDTH / 8)

// scratchpad, word addressed
`define DMEM_AWIDTH 10
`define DMEM_DEPTH  (1 << `DMEM_AWIDTH)

// burst memory keeps this many word-address bits, the rest are ignored
`define EXT_AWIDTH 10
`define EXT_DEPTH  (1 << `EXT_AWIDTH)

`endif

/* hdl/dma_pkg.sv */
package dma_pkg;

  // controller sequencing
  typedef enum logic [2:0] {
    IDLE,
    WRITE_DDR,
    WRITE_DDR_DELAY,
    READ_DDR,
    DONE
  } dma_state_t;

  // burst type on the request channels
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  // log2 of bytes per beat
  typedef logic [2:0] beat_size_t;

endpackage

/* hdl/dma_controller.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_controller (
  input  logic                    clk,
  input  logic                    rst_n,

  output logic                    dma_read_request_valid,
  input  logic                    dma_read_request_ready,
  output logic [`AXI_AWIDTH-1:0]  dma_read_addr,
  output logic [31:0]             dma_read_len,
  output dma_pkg::beat_size_t     dma_read_size,
  output dma_pkg::burst_t         dma_read_burst,
  input  logic [`AXI_DWIDTH-1:0]  dma_read_data,
  input  logic                    dma_read_data_valid,
  output logic                    dma_read_data_ready,

  output logic                    dma_write_request_valid,
  input  logic                    dma_write_request_ready,
  output logic [`AXI_AWIDTH-1:0]  dma_write_addr,
  output logic [31:0]             dma_write_len,
  output dma_pkg::beat_size_t     dma_write_size,
  output dma_pkg::burst_t         dma_write_burst,
  output logic [`AXI_DWIDTH-1:0]  dma_write_data,
  output logic                    dma_write_data_valid,
  input  logic                    dma_write_data_ready,

  input  logic                    dma_start,
  input  logic                    dma_dir,       // 1: dmem -> ddr, 0: ddr -> dmem
  input  logic [31:0]             dma_src_addr,
  input  logic [31:0]             dma_dst_addr,
  input  logic [31:0]             dma_len,
  output logic                    dma_done,
  output logic                    dma_idle,

  output logic [`DMEM_AWIDTH-1:0] dmem_addr,
  output logic [`AXI_DWIDTH-1:0]  dmem_din,
  input  logic [`AXI_DWIDTH-1:0]  dmem_dout,
  output logic [`AXI_STRB_W-1:0]  dmem_wbe,
  output logic                    dmem_en
);
  import dma_pkg::*;

  dma_state_t  state;
  dma_state_t  state_next;
  logic [31:0] read_cnt;
  logic [31:0] write_cnt;
  logic [31:0] dmem_word;
  logic        done_q;

  logic read_req_fire;
  logic read_data_fire;
  logic write_req_fire;
  logic write_data_fire;

  assign read_req_fire   = dma_read_request_valid & dma_read_request_ready;
  assign read_data_fire  = dma_read_data_valid & dma_read_data_ready;
  assign write_req_fire  = dma_write_request_valid & dma_write_request_ready;
  assign write_data_fire = dma_write_data_valid & dma_write_data_ready;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (dma_start) begin
          state_next = dma_dir ? WRITE_DDR : READ_DDR;
        end
      end
      READ_DDR: begin
        if (read_cnt == dma_len) begin
          state_next = DONE;
        end
      end
      WRITE_DDR: begin
        // one cycle to fetch the first word from dmem
        if (write_req_fire) begin
          state_next = WRITE_DDR_DELAY;
        end
      end
      WRITE_DDR_DELAY: begin
        if (write_cnt == dma_len && write_data_fire) begin // count runs one ahead
          state_next = DONE;
        end
      end
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || state == IDLE) begin
      read_cnt  <= '0;
      write_cnt <= '0;
    end else begin
      if (read_data_fire) begin
        read_cnt <= read_cnt + 1;
      end
      if ((state == WRITE_DDR && write_req_fire) || write_data_fire) begin
        write_cnt <= write_cnt + 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || (state == IDLE && dma_start)) begin
      done_q <= 1'b0;
    end else if (state == DONE) begin
      done_q <= 1'b1;
    end
  end

  assign dma_idle = state == IDLE;
  assign dma_done = done_q & ~dma_start;

  // single request per transfer, the burst is still running once read_cnt moves
  assign dma_read_request_valid = state == READ_DDR && read_cnt == 32'd0;
  assign dma_read_addr          = dma_src_addr;
  assign dma_read_len           = dma_len - 32'd1;
  assign dma_read_size          = beat_size_t'($clog2(`AXI_STRB_W));
  assign dma_read_burst         = INCR;
  assign dma_read_data_ready    = state == READ_DDR;

  assign dma_write_request_valid = state == WRITE_DDR;
  assign dma_write_addr          = dma_dst_addr;
  assign dma_write_len           = dma_len - 32'd1;
  assign dma_write_size          = beat_size_t'($clog2(`AXI_STRB_W));
  assign dma_write_burst         = INCR;
  assign dma_write_data_valid    = state == WRITE_DDR_DELAY;
  assign dma_write_data          = dmem_dout;

  assign dmem_word = (state == READ_DDR) ? dma_dst_addr + read_cnt :
                                           dma_src_addr + write_cnt;
  assign dmem_addr = dmem_word[`DMEM_AWIDTH-1:0];
  assign dmem_din  = dma_read_data;
  assign dmem_wbe  = read_data_fire ? {`AXI_STRB_W{1'b1}} : '0;
  assign dmem_en   = (state == WRITE_DDR) | write_data_fire | read_data_fire;

endmodule

/* hdl/dmem.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module dmem (
  input  logic                    clk,
  input  logic                    en,
  input  logic [`AXI_STRB_W-1:0]  wbe,
  input  logic [`DMEM_AWIDTH-1:0] addr,
  input  logic [`AXI_DWIDTH-1:0]  din,
  output logic [`AXI_DWIDTH-1:0]  dout
);

  logic [`AXI_DWIDTH-1:0] mem [`DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (wbe[i]) begin
          mem[addr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
      dout <= mem[addr]; // old word on a write
    end
  end

endmodule

/* hdl/burst_mem.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module burst_mem (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   dma_read_request_valid,
  output logic                   dma_read_request_ready,
  input  logic [`AXI_AWIDTH-1:0] dma_read_addr,       // byte address
  input  logic [31:0]            dma_read_len,        // beats - 1
  input  dma_pkg::beat_size_t    dma_read_size,
  input  dma_pkg::burst_t        dma_read_burst,
  output logic [`AXI_DWIDTH-1:0] dma_read_data,
  output logic                   dma_read_data_valid,
  input  logic                   dma_read_data_ready,

  input  logic                   dma_write_request_valid,
  output logic                   dma_write_request_ready,
  input  logic [`AXI_AWIDTH-1:0] dma_write_addr,      // byte address
  input  logic [31:0]            dma_write_len,
  input  dma_pkg::beat_size_t    dma_write_size,
  input  dma_pkg::burst_t        dma_write_burst,
  input  logic [`AXI_DWIDTH-1:0] dma_write_data,
  input  logic                   dma_write_data_valid,
  output logic                   dma_write_data_ready,

  input  logic                   host_en,
  input  logic                   host_we,
  input  logic [`AXI_AWIDTH-1:0] host_addr,           // word address
  input  logic [`AXI_DWIDTH-1:0] host_wdata,
  output logic [`AXI_DWIDTH-1:0] host_rdata
);
  import dma_pkg::*;

  typedef enum logic [1:0] {MEM_IDLE, MEM_READ, MEM_WRITE} mem_state_t;

  mem_state_t             state;
  mem_state_t             state_next;
  logic                   accept;
  logic [`AXI_AWIDTH-1:0] beat_addr;   // address of the next beat
  logic [31:0]            beats_left;
  burst_t                 burst_q;
  beat_size_t             size_q;
  logic [`AXI_DWIDTH-1:0] mem [`EXT_DEPTH];

  logic                   rd_req_fire;
  logic                   wr_req_fire;
  logic                   rd_beat_fire;
  logic                   wr_beat_fire;
  logic                   last_beat;
  logic                   host_go;
  logic                   rd_load;
  logic [`EXT_AWIDTH-1:0] rd_idx;
  logic                   mem_we;
  logic [`EXT_AWIDTH-1:0] mem_widx;
  logic [`AXI_DWIDTH-1:0] mem_wdata;

  function automatic logic [`AXI_AWIDTH-1:0] next_addr(input logic [`AXI_AWIDTH-1:0] addr,
                                                       input burst_t burst,
                                                       input beat_size_t size);
    logic [`AXI_AWIDTH-1:0] step;
    step       = '0;
    step[size] = 1'b1;
    return (burst == FIXED) ? addr : addr + step; // wrap is treated as incr
  endfunction

  assign dma_read_request_ready  = accept;
  assign dma_write_request_ready = accept & ~dma_read_request_valid; // reads win
  assign dma_write_data_ready    = state == MEM_WRITE;

  assign rd_req_fire  = dma_read_request_valid & dma_read_request_ready;
  assign wr_req_fire  = dma_write_request_valid & dma_write_request_ready;
  assign rd_beat_fire = dma_read_data_valid & dma_read_data_ready;
  assign wr_beat_fire = dma_write_data_valid & dma_write_data_ready;
  assign last_beat    = beats_left == 32'd0;

  always_comb begin
    state_next = state;
    case (state)
      MEM_IDLE: begin
        if (rd_req_fire) begin
          state_next = MEM_READ;
        end else if (wr_req_fire) begin
          state_next = MEM_WRITE;
        end
      end
      MEM_READ:  if (rd_beat_fire && last_beat) state_next = MEM_IDLE;
      MEM_WRITE: if (wr_beat_fire && last_beat) state_next = MEM_IDLE;
      default:   state_next = MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state               <= MEM_IDLE;
      accept              <= 1'b0;
      dma_read_data_valid <= 1'b0;
    end else begin
      state  <= state_next;
      accept <= state_next == MEM_IDLE;
      if (rd_req_fire) begin
        dma_read_data_valid <= 1'b1;
      end else if (rd_beat_fire && last_beat) begin
        dma_read_data_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req_fire) begin
      beat_addr  <= next_addr(dma_read_addr, dma_read_burst, dma_read_size);
      beats_left <= dma_read_len;
      burst_q    <= dma_read_burst;
      size_q     <= dma_read_size;
    end else if (wr_req_fire) begin
      beat_addr  <= dma_write_addr;
      beats_left <= dma_write_len;
      burst_q    <= dma_write_burst;
      size_q     <= dma_write_size;
    end else if ((rd_beat_fire && !last_beat) || wr_beat_fire) begin
      beat_addr  <= next_addr(beat_addr, burst_q, size_q);
      beats_left <= beats_left - 32'd1;
    end
  end

  // host only touches the array while no burst is starting or running
  assign host_go   = state == MEM_IDLE && host_en && !rd_req_fire && !wr_req_fire;
  assign rd_load   = rd_req_fire | (rd_beat_fire & ~last_beat);
  assign rd_idx    = rd_req_fire ? dma_read_addr[`EXT_AWIDTH+1:2] : beat_addr[`EXT_AWIDTH+1:2];
  assign mem_we    = wr_beat_fire | (host_go & host_we);
  assign mem_widx  = host_go ? host_addr[`EXT_AWIDTH-1:0] : beat_addr[`EXT_AWIDTH+1:2];
  assign mem_wdata = host_go ? host_wdata : dma_write_data;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_widx] <= mem_wdata;
    end
    if (rd_load) begin
      dma_read_data <= mem[rd_idx];
    end
    if (host_go && !host_we) begin
      host_rdata <= mem[host_addr[`EXT_AWIDTH-1:0]];
    end
  end

endmodule

/* hdl/host_access_arb.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module host_access_arb (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    dma_idle,
  input  logic                    host_en,
  input  logic                    host_sel,      // 0: dmem, 1: external memory
  input  logic                    host_we,
  input  logic [`AXI_AWIDTH-1:0]  host_addr,
  input  logic [`AXI_DWIDTH-1:0]  host_wdata,
  output logic [`AXI_DWIDTH-1:0]  host_rdata,

  input  logic [`DMEM_AWIDTH-1:0] ctl_dmem_addr,
  input  logic [`AXI_DWIDTH-1:0]  ctl_dmem_din,
  input  logic [`AXI_STRB_W-1:0]  ctl_dmem_wbe,
  input  logic                    ctl_dmem_en,

  output logic [`DMEM_AWIDTH-1:0] mem_addr,
  output logic [`AXI_DWIDTH-1:0]  mem_din,
  output logic [`AXI_STRB_W-1:0]  mem_wbe,
  output logic                    mem_en,
  input  logic [`AXI_DWIDTH-1:0]  mem_dout,

  output logic                    ext_host_en,
  output logic                    ext_host_we,
  input  logic [`AXI_DWIDTH-1:0]  ext_host_rdata
);

  logic                   host_go;
  logic                   dmem_go;
  logic                   rd_pending;
  logic                   rd_sel;
  logic [`AXI_DWIDTH-1:0] rdata_q;

  assign host_go = dma_idle & host_en; // dropped while a transfer runs
  assign dmem_go = host_go & ~host_sel;

  assign mem_en   = dma_idle ? dmem_go : ctl_dmem_en;
  assign mem_wbe  = dma_idle ? {`AXI_STRB_W{dmem_go & host_we}} : ctl_dmem_wbe;
  assign mem_addr = dma_idle ? host_addr[`DMEM_AWIDTH-1:0] : ctl_dmem_addr;
  assign mem_din  = dma_idle ? host_wdata : ctl_dmem_din;

  assign ext_host_en = host_go & host_sel;
  assign ext_host_we = host_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= host_go & ~host_we;
    end
  end

  always_ff @(posedge clk) begin
    if (host_go && !host_we) begin
      rd_sel <= host_sel;
    end
    if (rd_pending) begin
      rdata_q <= host_rdata;
    end
  end

  // live target data in the cycle after a read, held value otherwise
  assign host_rdata = rd_pending ? (rd_sel ? ext_host_rdata : mem_dout) : rdata_q;

endmodule

/* hdl/dma_subsystem.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_subsystem (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   dma_start,
  input  logic                   dma_dir,
  input  logic [31:0]            dma_src_addr,   // dmem word or ddr byte address
  input  logic [31:0]            dma_dst_addr,
  input  logic [31:0]            dma_len,
  output logic                   dma_done,
  output logic                   dma_idle,

  input  logic                   host_en,
  input  logic                   host_sel,
  input  logic                   host_we,
  input  logic [`AXI_AWIDTH-1:0] host_addr,      // word address on both targets
  input  logic [`AXI_DWIDTH-1:0] host_wdata,
  output logic [`AXI_DWIDTH-1:0] host_rdata
);
  import dma_pkg::*;

  logic                    rd_req_valid, rd_req_ready, rd_data_valid, rd_data_ready;
  logic [`AXI_AWIDTH-1:0]  rd_addr;
  logic [31:0]             rd_len;
  beat_size_t              rd_size;
  burst_t                  rd_burst;
  logic [`AXI_DWIDTH-1:0]  rd_data;

  logic                    wr_req_valid, wr_req_ready, wr_data_valid, wr_data_ready;
  logic [`AXI_AWIDTH-1:0]  wr_addr;
  logic [31:0]             wr_len;
  beat_size_t              wr_size;
  burst_t                  wr_burst;
  logic [`AXI_DWIDTH-1:0]  wr_data;

  logic [`DMEM_AWIDTH-1:0] ctl_addr, mem_addr;
  logic [`AXI_DWIDTH-1:0]  ctl_din, mem_din, mem_dout;
  logic [`AXI_STRB_W-1:0]  ctl_wbe, mem_wbe;
  logic                    ctl_en, mem_en;

  logic                    ext_host_en, ext_host_we;
  logic [`AXI_DWIDTH-1:0]  ext_host_rdata;

  dma_controller u_dma_controller (
    .clk, .rst_n,
    .dma_read_request_valid (rd_req_valid),  .dma_read_request_ready (rd_req_ready),
    .dma_read_addr          (rd_addr),       .dma_read_len           (rd_len),
    .dma_read_size          (rd_size),       .dma_read_burst         (rd_burst),
    .dma_read_data          (rd_data),       .dma_read_data_valid    (rd_data_valid),
    .dma_read_data_ready    (rd_data_ready),
    .dma_write_request_valid(wr_req_valid),  .dma_write_request_ready(wr_req_ready),
    .dma_write_addr         (wr_addr),       .dma_write_len          (wr_len),
    .dma_write_size         (wr_size),       .dma_write_burst        (wr_burst),
    .dma_write_data         (wr_data),       .dma_write_data_valid   (wr_data_valid),
    .dma_write_data_ready   (wr_data_ready),
    .dma_start, .dma_dir, .dma_src_addr, .dma_dst_addr, .dma_len, .dma_done, .dma_idle,
    .dmem_addr(ctl_addr), .dmem_din(ctl_din), .dmem_dout(mem_dout),
    .dmem_wbe (ctl_wbe),  .dmem_en (ctl_en)
  );

  dmem u_dmem (
    .clk, .en(mem_en), .wbe(mem_wbe), .addr(mem_addr), .din(mem_din), .dout(mem_dout)
  );

  burst_mem u_burst_mem (
    .clk, .rst_n,
    .dma_read_request_valid (rd_req_valid),  .dma_read_request_ready (rd_req_ready),
    .dma_read_addr          (rd_addr),       .dma_read_len           (rd_len),
    .dma_read_size          (rd_size),       .dma_read_burst         (rd_burst),
    .dma_read_data          (rd_data),       .dma_read_data_valid    (rd_data_valid),
    .dma_read_data_ready    (rd_data_ready),
    .dma_write_request_valid(wr_req_valid),  .dma_write_request_ready(wr_req_ready),
    .dma_write_addr         (wr_addr),       .dma_write_len          (wr_len),
    .dma_write_size         (wr_size),       .dma_write_burst        (wr_burst),
    .dma_write_data         (wr_data),       .dma_write_data_valid   (wr_data_valid),
    .dma_write_data_ready   (wr_data_ready),
    .host_en(ext_host_en), .host_we(ext_host_we), .host_addr, .host_wdata,
    .host_rdata(ext_host_rdata)
  );

  host_access_arb u_host_access_arb (
    .clk, .rst_n, .dma_idle, .host_en, .host_sel, .host_we, .host_addr, .host_wdata,
    .host_rdata,
    .ctl_dmem_addr(ctl_addr), .ctl_dmem_din(ctl_din), .ctl_dmem_wbe(ctl_wbe),
    .ctl_dmem_en  (ctl_en),
    .mem_addr, .mem_din, .mem_wbe, .mem_en, .mem_dout,
    .ext_host_en, .ext_host_we, .ext_host_rdata
  );

endmodule

/* tests/tb_dma_subsystem.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module tb_dma_subsystem;
  import dma_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS     = 8;
  localparam int POKE_IDX     = 1000;            // outside every transfer window
  localparam int IDX_MASK     = `DMEM_DEPTH - 1; // both memories hold the same word count

  typedef struct packed {
    logic                    dir;   // 0: ext -> dmem, 1: dmem -> ext
    logic [`DMEM_AWIDTH-1:0] src;   // word index that becomes a byte address on the ext side
    logic [`DMEM_AWIDTH-1:0] dst;
    logic [31:0]             len;
    logic [15:0]             seed;  // 0 keeps what earlier rows left in the source
    logic                    poke;  // host writes attempted mid-transfer
  } xfer_t;

  xfer_t xfers [NUM_ROWS] = '{
    '{1'b0, 10'd100,  10'd200,  32'd1,  16'h0001, 1'b0},
    '{1'b0, 10'd300,  10'd400,  32'd7,  16'h0002, 1'b0},
    '{1'b1, 10'd500,  10'd600,  32'd1,  16'h0003, 1'b0},
    '{1'b1, 10'd50,   10'd700,  32'd16, 16'h0004, 1'b1},
    '{1'b0, 10'd700,  10'd800,  32'd16, 16'h0000, 1'b0}, // brings row 3's block back
    '{1'b0, 10'd10,   10'd20,   32'd32, 16'h0005, 1'b1},
    '{1'b1, 10'd20,   10'd900,  32'd32, 16'h0000, 1'b0}, // sends row 5's result out again
    '{1'b1, 10'd1020, 10'd1021, 32'd3,  16'h0006, 1'b0}
  };

  logic                   clk;
  logic                   rst_n;
  logic                   dma_start;
  logic                   dma_dir;
  logic [31:0]            dma_src_addr;
  logic [31:0]            dma_dst_addr;
  logic [31:0]            dma_len;
  logic                   dma_done;
  logic                   dma_idle;
  logic                   host_en;
  logic                   host_sel;
  logic                   host_we;
  logic [`AXI_AWIDTH-1:0] host_addr;
  logic [`AXI_DWIDTH-1:0] host_wdata;
  logic [`AXI_DWIDTH-1:0] host_rdata;

  logic [`AXI_DWIDTH-1:0] dmem_model [`DMEM_DEPTH];
  logic [`AXI_DWIDTH-1:0] ext_model [`EXT_DEPTH];
  logic                   done_expected;

  dma_subsystem u_dma_subsystem (
    .clk, .rst_n, .dma_start, .dma_dir, .dma_src_addr, .dma_dst_addr, .dma_len,
    .dma_done, .dma_idle, .host_en, .host_sel, .host_we, .host_addr, .host_wdata,
    .host_rdata
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_word(input string name, input logic [`AXI_DWIDTH-1:0] exp,
                            input logic [`AXI_DWIDTH-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic logic [`AXI_DWIDTH-1:0] fill_word(input logic [15:0] seed, input int idx);
    return $urandom() ^ {seed, 16'(idx)};
  endfunction

  function automatic logic [`AXI_DWIDTH-1:0] model_read(input logic sel, input int idx);
    return sel ? ext_model[idx] : dmem_model[idx];
  endfunction

  function automatic void model_write(input logic sel, input int idx,
                                      input logic [`AXI_DWIDTH-1:0] data);
    if (sel) begin
      ext_model[idx] = data;
    end else begin
      dmem_model[idx] = data;
    end
  endfunction

  // read data shows up one cycle after the access
  task automatic host_access(input logic sel, input logic we, input int idx,
                             input logic [`AXI_DWIDTH-1:0] wdata,
                             output logic [`AXI_DWIDTH-1:0] rdata);
    @(negedge clk);
    host_en    = 1'b1;
    host_sel   = sel;
    host_we    = we;
    host_addr  = idx;
    host_wdata = wdata;
    @(negedge clk);
    rdata   = host_rdata;
    host_en = 1'b0;
  endtask

  task automatic host_write(input logic sel, input int idx, input logic [`AXI_DWIDTH-1:0] data);
    logic [`AXI_DWIDTH-1:0] scratch;
    host_access(sel, 1'b1, idx, data, scratch);
    model_write(sel, idx, data);
  endtask

  task automatic host_read_check(input logic sel, input int idx);
    logic [`AXI_DWIDTH-1:0] rd;
    host_access(sel, 1'b0, idx, '0, rd);
    check_word($sformatf("host_rdata %s[%0d]", sel ? "ext" : "dmem", idx),
               model_read(sel, idx), rd);
  endtask

  task automatic run_row(input xfer_t x);
    logic [`AXI_DWIDTH-1:0] scratch;
    int src;
    int dst;
    int len;
    src = int'(x.src);
    dst = int'(x.dst);
    len = int'(x.len);
    if (x.seed != 16'h0) begin
      for (int i = 0; i < len; i++) begin
        host_write(~x.dir, (src + i) & IDX_MASK, fill_word(x.seed, (src + i) & IDX_MASK));
      end
    end
    @(negedge clk);
    check_flag("dma_done", done_expected, dma_done); // sticky while idle
    check_flag("dma_idle", 1'b1, dma_idle);
    dma_dir      = x.dir;
    dma_src_addr = x.dir ? 32'(src) : 32'(src) << 2;
    dma_dst_addr = x.dir ? 32'(dst) << 2 : 32'(dst);
    dma_len      = x.len;
    dma_start    = 1'b1;
    #1;
    check_flag("dma_done", 1'b0, dma_done); // masked by the start pulse
    @(negedge clk);
    dma_start = 1'b0;
    check_flag("dma_idle", 1'b0, dma_idle);
    if (x.poke) begin
      host_access(1'b0, 1'b1, POKE_IDX, ~model_read(1'b0, POKE_IDX), scratch);
      host_access(1'b1, 1'b1, POKE_IDX, ~model_read(1'b1, POKE_IDX), scratch);
    end
    while (dma_done !== 1'b1) begin
      check_flag("dma_idle", 1'b0, dma_idle);
      @(negedge clk);
    end
    check_flag("dma_idle", 1'b1, dma_idle); // idle comes back together with done
    done_expected = 1'b1;
    for (int i = 0; i < len; i++) begin
      model_write(x.dir, (dst + i) & IDX_MASK, model_read(~x.dir, (src + i) & IDX_MASK));
    end
    for (int k = -2; k < len + 2; k++) begin
      host_read_check(x.dir, (dst + k) & IDX_MASK);
    end
    if (x.poke) begin
      host_read_check(1'b0, POKE_IDX);
      host_read_check(1'b1, POKE_IDX);
    end
  endtask

  // background fill and sampling, then per row the transfer and its host traffic
  function automatic int watchdog_cycles();
    int total;
    total = RESET_CYCLES + 4 * `DMEM_DEPTH + 4 * `DMEM_DEPTH / 61 + 64;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += (int'(xfers[r].len) + 64) + (4 * int'(xfers[r].len) + 32);
    end
    return total;
  endfunction

  initial begin
    dma_state_t state_at_timeout;
    @(posedge clk);
    repeat (watchdog_cycles()) @(posedge clk);
    state_at_timeout = u_dma_subsystem.u_dma_controller.state;
    $display("timeout waiting for dma_done, controller in %s", state_at_timeout.name());
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'hf56b));
    rst_n         = 1'b0;
    dma_start     = 1'b0;
    dma_dir       = 1'b0;
    dma_src_addr  = '0;
    dma_dst_addr  = '0;
    dma_len       = 32'd1;
    host_en       = 1'b0;
    host_sel      = 1'b0;
    host_we       = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    done_expected = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("dma_idle", 1'b1, dma_idle);
    check_flag("dma_done", 1'b0, dma_done);
    // known contents everywhere so untouched neighbours can be checked
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
      host_write(1'b0, i, fill_word(16'h00a5, i));
      host_write(1'b1, i, fill_word(16'h005a, i));
    end
    for (int i = 3; i < `DMEM_DEPTH; i += 61) begin
      host_read_check(1'b0, i);
      host_read_check(1'b1, i);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(xfers[r]);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_controller.sv
hdl/dmem.sv
hdl/burst_mem.sv
hdl/host_access_arb.sv
hdl/dma_subsystem.sv
tests/tb_dma_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DMA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_dma_subsystem -Mdir "$OBJ" -o tb_dma_subsystem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_dma_subsystem" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
